/* design/videoGeometryPkg.sv */
package videoGeometryPkg;

// Chunks are a power of two pixels wide, so the left padding is a whole number of chunks
localparam int chunkBits = 5;
localparam int chunkSize = 1 << chunkBits;

// Largest supported frame is 2048 by 2048 pixels
localparam int hactiveBits = 11;
localparam int vactiveBits = 11;

// A row holds this many chunks at most
localparam int chunkNumBits = hactiveBits - chunkBits;

// RGB565 style pixels
localparam int pixelBits = 16;

typedef logic [vactiveBits-1:0] rowType;
typedef logic [chunkNumBits-1:0] chunkNumType;
typedef logic [pixelBits-1:0] pixelType;

// Position of a pixel inside its chunk
typedef logic [chunkBits-1:0] pixelIndexType;

// Chunk request as it travels between pipeline elements
// The row sits in the upper bits and the chunk number in the lower bits
typedef struct packed {
    rowType row;
    chunkNumType chunk;
} chunkRequestType;

endpackage

/* design/paddingControlPkg.sv */
package paddingControlPkg;

import videoGeometryPkg::*;

// One-hot states of the request side FSM
typedef enum logic [2:0] {
    requestIdle = 3'b001,
    requestRead = 3'b010,
    requestStore = 3'b100
} requestStateType;

// One-hot states of the response side FSM
typedef enum logic [2:0] {
    responseIdle = 3'b001,
    responseRead = 3'b010,
    responseStore = 3'b100
} responseStateType;

// A downstream request waiting for its pixels
// The window decision is made once on the request side and rides along here
typedef struct packed {
    logic insideSource;
    chunkRequestType request;
} pendingChunkType;

endpackage

/* design/chunkQueueIf.sv */
interface chunkQueueIf
    import videoGeometryPkg::*;
#(
    parameter type payloadType = chunkRequestType
)();

// Write side of the queue
logic writeEnable;
logic full;
payloadType writeData;

// Read side of the queue, data follows readEnable by one clock
logic readEnable;
logic empty;
payloadType readData;

// Views of the blocks that push into and pop from the queue
modport producer (output writeEnable, output writeData, input full);
modport consumer (output readEnable, input empty, input readData);

// Views of the queue itself
modport writeSide (input writeEnable, input writeData, output full);
modport readSide (input readEnable, output empty, output readData);

endinterface

/* design/chunkQueue.sv */
module chunkQueue
    import videoGeometryPkg::*;
#(
    parameter type payloadType = chunkRequestType,
    parameter int fifoAddrBits = chunkNumBits
)(
    input logic scalerClock,
    input logic reset,
    chunkQueueIf.writeSide writePort,
    chunkQueueIf.readSide readPort
);

localparam int queueDepth = 1 << fifoAddrBits;

payloadType storage [queueDepth];

// Pointers carry one extra wrap bit to tell a full queue from an empty one
logic [fifoAddrBits:0] writePointer;
logic [fifoAddrBits:0] readPointer;

logic writeAccept;
logic readAccept;

// Requests against a full or empty queue are ignored
assign writeAccept = writePort.writeEnable && !writePort.full;
assign readAccept = readPort.readEnable && !readPort.empty;

// Same address and same wrap bit means nothing is stored
assign readPort.empty = (writePointer == readPointer);

// Same address but opposite wrap bit means the writer is a whole lap ahead
assign writePort.full = (writePointer[fifoAddrBits] != readPointer[fifoAddrBits]) &&
                        (writePointer[fifoAddrBits-1:0] == readPointer[fifoAddrBits-1:0]);

always_ff @(posedge scalerClock or posedge reset) begin
    if (reset) begin
        // Queue comes up empty
        writePointer <= '0;
        readPointer <= '0;
    end else begin
        if (writeAccept) begin
            writePointer <= writePointer + 1'b1;
        end
        if (readAccept) begin
            readPointer <= readPointer + 1'b1;
        end
    end
end

// Storage and the read register hold payload only
always_ff @(posedge scalerClock) begin
    if (writeAccept) begin
        storage[writePointer[fifoAddrBits-1:0]] <= writePort.writeData;
    end
    // Entry shows up on readData the clock after the read pulse
    // and stays there until the next read
    if (readAccept) begin
        readPort.readData <= storage[readPointer[fifoAddrBits-1:0]];
    end
end

endmodule

/* design/requestTranslator.sv */
module requestTranslator
    import videoGeometryPkg::*;
    import paddingControlPkg::*;
(
    input logic scalerClock,
    input logic reset,

    // Window placement and source size
    input rowType padTopRows,
    input rowType sourceRows,
    input chunkNumType padLeftChunks,
    input chunkNumType sourceChunks,

    // Downstream request FIFO, data valid one clock after readEnable
    output logic downstreamRequestFifoReadEnable,
    input logic downstreamRequestFifoEmpty,
    input chunkRequestType downstreamRequestFifoReadData,

    // Translated requests for the upstream element
    chunkQueueIf.producer upstreamQueue,

    // Every request, tagged with its window decision, for the response side
    chunkQueueIf.producer pendingQueue
);

requestStateType requestState;

rowType requestedRow;
chunkNumType requestedChunk;

// Window edges one bit wider so a window touching the frame edge cannot wrap
logic [vactiveBits:0] rowLimit;
logic [chunkNumBits:0] chunkLimit;

logic insideSource;
chunkRequestType translatedRequest;

assign requestedRow = downstreamRequestFifoReadData.row;
assign requestedChunk = downstreamRequestFifoReadData.chunk;

assign rowLimit = {1'b0, padTopRows} + {1'b0, sourceRows};
assign chunkLimit = {1'b0, padLeftChunks} + {1'b0, sourceChunks};

// Lower edges inclusive, upper edges exclusive
// A source size below the real one trims the bottom or right of the picture
assign insideSource = (requestedRow >= padTopRows) &&
                      ({1'b0, requestedRow} < rowLimit) &&
                      (requestedChunk >= padLeftChunks) &&
                      ({1'b0, requestedChunk} < chunkLimit);

// Shift back up and left into source coordinates
assign translatedRequest.row = requestedRow - padTopRows;
assign translatedRequest.chunk = requestedChunk - padLeftChunks;

always_ff @(posedge scalerClock or posedge reset) begin
    if (reset) begin
        requestState <= requestIdle;
        downstreamRequestFifoReadEnable <= 1'b0;
        upstreamQueue.writeEnable <= 1'b0;
        pendingQueue.writeEnable <= 1'b0;
    end else begin
        // Queue writes last a single clock
        upstreamQueue.writeEnable <= 1'b0;
        pendingQueue.writeEnable <= 1'b0;

        case (requestState)
            requestIdle: begin
                // Only take a request when both queues can receive it
                if (!downstreamRequestFifoEmpty && !upstreamQueue.full && !pendingQueue.full) begin
                    downstreamRequestFifoReadEnable <= 1'b1;
                    requestState <= requestRead;
                end
            end

            requestRead: begin
                downstreamRequestFifoReadEnable <= 1'b0;
                // A write issued during idle may have just filled a queue, so look again
                if (!upstreamQueue.full && !pendingQueue.full) begin
                    requestState <= requestStore;
                end
            end

            requestStore: begin
                // Padding chunks need nothing from upstream
                upstreamQueue.writeEnable <= insideSource;
                pendingQueue.writeEnable <= 1'b1;
                requestState <= requestIdle;
            end

            default: begin
                downstreamRequestFifoReadEnable <= 1'b0;
                requestState <= requestIdle;
            end
        endcase
    end
end

// Queue payloads are captured alongside the write enables
always_ff @(posedge scalerClock) begin
    if (requestState == requestStore) begin
        upstreamQueue.writeData <= translatedRequest;
        pendingQueue.writeData <= '{insideSource: insideSource,
                                    request: downstreamRequestFifoReadData};
    end
end

endmodule

/* design/responseAssembler.sv */
module responseAssembler
    import videoGeometryPkg::*;
    import paddingControlPkg::*;
(
    input logic scalerClock,
    input logic reset,

    // Color of the bars around the source picture
    input pixelType padColor,

    // Requests waiting for their pixels, in arrival order
    chunkQueueIf.consumer pendingQueue,

    // Upstream response, a pixel moves when writeEnable is high and full is low
    input logic upstreamResponseFifoWriteEnable,
    output logic upstreamResponseFifoFull,
    input pixelType upstreamResponseFifoWriteData,

    // Downstream response FIFO
    output logic downstreamResponseFifoWriteEnable,
    input logic downstreamResponseFifoFull,
    output pixelType downstreamResponseFifoWriteData
);

responseStateType responseState;

// Pixels already sent for the current chunk
pixelIndexType pixelCount;

logic insideSource;
logic acceptUpstream;
logic pixelWrite;
logic lastPixel;
pixelType pixelValue;

// Window decision made on the request side
assign insideSource = pendingQueue.readData.insideSource;

// Upstream pixel handed over this clock
assign acceptUpstream = !upstreamResponseFifoFull && upstreamResponseFifoWriteEnable;

always_comb begin
    pixelWrite = 1'b0;
    if (responseState == responseStore) begin
        // Source chunks move at the upstream pace, padding at the downstream pace
        if (insideSource) begin
            pixelWrite = acceptUpstream;
        end else begin
            pixelWrite = !downstreamResponseFifoFull;
        end
    end
end

assign lastPixel = pixelWrite && (pixelCount == pixelIndexType'(chunkSize - 1));
assign pixelValue = insideSource ? upstreamResponseFifoWriteData : padColor;

always_ff @(posedge scalerClock or posedge reset) begin
    if (reset) begin
        responseState <= responseIdle;
        pendingQueue.readEnable <= 1'b0;
        // Upstream stays blocked until a source chunk is active
        upstreamResponseFifoFull <= 1'b1;
        downstreamResponseFifoWriteEnable <= 1'b0;
        pixelCount <= '0;
    end else begin
        // Every chosen pixel lands downstream on the next clock
        downstreamResponseFifoWriteEnable <= pixelWrite;

        // The count wraps to zero on its own after the last pixel
        if (pixelWrite) begin
            pixelCount <= pixelCount + pixelIndexType'(1);
        end

        case (responseState)
            responseIdle: begin
                upstreamResponseFifoFull <= 1'b1;
                if (!pendingQueue.empty) begin
                    pendingQueue.readEnable <= 1'b1;
                    responseState <= responseRead;
                end
            end

            responseRead: begin
                // Entry reaches readData at the end of this clock
                pendingQueue.readEnable <= 1'b0;
                upstreamResponseFifoFull <= 1'b1;
                responseState <= responseStore;
            end

            responseStore: begin
                // Open upstream only for source chunks with room downstream.
                // A pixel already accepted as full rises uses the one write
                // the downstream FIFO still takes.
                // Close again on the last pixel so nothing is taken for the next entry
                upstreamResponseFifoFull <= !insideSource || downstreamResponseFifoFull ||
                                            lastPixel;

                if (lastPixel) begin
                    // Go straight for the next entry when one is waiting
                    if (!pendingQueue.empty) begin
                        pendingQueue.readEnable <= 1'b1;
                        responseState <= responseRead;
                    end else begin
                        responseState <= responseIdle;
                    end
                end
            end

            default: begin
                pendingQueue.readEnable <= 1'b0;
                upstreamResponseFifoFull <= 1'b1;
                responseState <= responseIdle;
            end
        endcase
    end
end

// Pixel color is captured together with its write enable
always_ff @(posedge scalerClock) begin
    if (pixelWrite) begin
        downstreamResponseFifoWriteData <= pixelValue;
    end
end

endmodule

/* design/videoPaddingFilter.sv */
module videoPaddingFilter
    import videoGeometryPkg::*;
    import paddingControlPkg::*;
#(
    parameter int fifoAddrBits = chunkNumBits
)(
    input logic scalerClock,
    input logic reset,

    // Padding configuration
    input rowType padTopRows,
    input chunkNumType padLeftChunks,
    input rowType sourceRows,
    input chunkNumType sourceChunks,
    input pixelType padColor,

    // Chunk requests read from the downstream element
    output logic downstreamRequestFifoReadEnable,
    input logic downstreamRequestFifoEmpty,
    input chunkRequestType downstreamRequestFifoReadData,

    // Pixels written back to the downstream element
    output logic downstreamResponseFifoWriteEnable,
    input logic downstreamResponseFifoFull,
    output pixelType downstreamResponseFifoWriteData,

    // Translated requests offered to the upstream element
    input logic upstreamRequestFifoReadEnable,
    output logic upstreamRequestFifoEmpty,
    output chunkRequestType upstreamRequestFifoReadData,

    // Source pixels written by the upstream element
    input logic upstreamResponseFifoWriteEnable,
    output logic upstreamResponseFifoFull,
    input pixelType upstreamResponseFifoWriteData
);

chunkQueueIf #(.payloadType(chunkRequestType)) upstreamQueueBus ();
chunkQueueIf #(.payloadType(pendingChunkType)) pendingQueueBus ();

// Upstream element pops the translated requests directly
assign upstreamQueueBus.readEnable = upstreamRequestFifoReadEnable;
assign upstreamRequestFifoEmpty = upstreamQueueBus.empty;
assign upstreamRequestFifoReadData = upstreamQueueBus.readData;

chunkQueue #(.payloadType(chunkRequestType), .fifoAddrBits(fifoAddrBits)) upstreamQueue (
    .scalerClock(scalerClock),
    .reset(reset),
    .writePort(upstreamQueueBus),
    .readPort(upstreamQueueBus)
);

// Keeps responses in request order while upstream pixels are outstanding
chunkQueue #(.payloadType(pendingChunkType), .fifoAddrBits(fifoAddrBits)) pendingQueue (
    .scalerClock(scalerClock),
    .reset(reset),
    .writePort(pendingQueueBus),
    .readPort(pendingQueueBus)
);

requestTranslator requestTranslator (
    .scalerClock(scalerClock),
    .reset(reset),
    .padTopRows(padTopRows),
    .sourceRows(sourceRows),
    .padLeftChunks(padLeftChunks),
    .sourceChunks(sourceChunks),
    .downstreamRequestFifoReadEnable(downstreamRequestFifoReadEnable),
    .downstreamRequestFifoEmpty(downstreamRequestFifoEmpty),
    .downstreamRequestFifoReadData(downstreamRequestFifoReadData),
    .upstreamQueue(upstreamQueueBus),
    .pendingQueue(pendingQueueBus)
);

responseAssembler responseAssembler (
    .scalerClock(scalerClock),
    .reset(reset),
    .padColor(padColor),
    .pendingQueue(pendingQueueBus),
    .upstreamResponseFifoWriteEnable(upstreamResponseFifoWriteEnable),
    .upstreamResponseFifoFull(upstreamResponseFifoFull),
    .upstreamResponseFifoWriteData(upstreamResponseFifoWriteData),
    .downstreamResponseFifoWriteEnable(downstreamResponseFifoWriteEnable),
    .downstreamResponseFifoFull(downstreamResponseFifoFull),
    .downstreamResponseFifoWriteData(downstreamResponseFifoWriteData)
);

endmodule

/* verification/scalerClockGen.sv */
module scalerClockGen (
    output logic scalerClock,
    output logic reset
);

localparam int halfPeriod = 4;
localparam int resetCycles = 8;

initial begin
    scalerClock = 1'b0;
    forever #halfPeriod scalerClock = ~scalerClock;
end

// Reset drops on a falling edge after eight full clocks
initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge scalerClock);
    @(negedge scalerClock);
    reset = 1'b0;
end

endmodule

/* verification/videoPaddingFilter_assert.sv */
module videoPaddingFilter_assert (
    input logic scalerClock,
    input logic reset,
    input logic downstreamRequestFifoReadEnable,
    input logic upstreamResponseFifoFull,
    input logic upstreamRequestFifoEmpty
);

// Number of protocol violations seen so far
int assertionFailures = 0;

// A request read is a single clock pulse, the translator needs three clocks per request
readEnableSinglePulse: assert property (
    @(posedge scalerClock) disable iff (reset)
    downstreamRequestFifoReadEnable |=> !downstreamRequestFifoReadEnable
) else begin
    assertionFailures++;
    $error("downstreamRequestFifoReadEnable was high on two consecutive cycles");
end

// Upstream pixels stay blocked while the filter is held in reset
upstreamBlockedInReset: assert property (
    @(posedge scalerClock)
    reset |=> upstreamResponseFifoFull
) else begin
    assertionFailures++;
    $error("upstreamResponseFifoFull was low during reset");
end

// Nothing can have been queued for upstream on the first clock out of reset
upstreamQueueEmptyAfterReset: assert property (
    @(posedge scalerClock)
    $fell(reset) |-> upstreamRequestFifoEmpty
) else begin
    assertionFailures++;
    $error("upstreamRequestFifoEmpty was low right after reset");
end

endmodule

bind videoPaddingFilter videoPaddingFilter_assert protocolChecks (
    .scalerClock(scalerClock),
    .reset(reset),
    .downstreamRequestFifoReadEnable(downstreamRequestFifoReadEnable),
    .upstreamResponseFifoFull(upstreamResponseFifoFull),
    .upstreamRequestFifoEmpty(upstreamRequestFifoEmpty)
);

/* verification/videoPaddingFilterTb.sv */
module videoPaddingFilterTb
    import videoGeometryPkg::*;
();

localparam logic [31:0] randomSeed = 32'hd177cb97;
localparam int requestCount = 60;
localparam int pixelTotal = requestCount * chunkSize;
localparam int resetTimeout = 64;
localparam int drainTimeout = 20000;
localparam int quietCycles = 64;

// Window of the source picture inside the padded frame
localparam int windowTop = 3;
localparam int windowRows = 5;
localparam int windowLeft = 2;
localparam int windowChunks = 4;
localparam pixelType padColorValue = 16'hf81f;

logic scalerClock;
logic reset;
rowType padTopRows;
chunkNumType padLeftChunks;
rowType sourceRows;
chunkNumType sourceChunks;
pixelType padColor;
logic downstreamRequestFifoReadEnable;
logic downstreamRequestFifoEmpty;
chunkRequestType downstreamRequestFifoReadData;
logic downstreamResponseFifoWriteEnable;
logic downstreamResponseFifoFull;
pixelType downstreamResponseFifoWriteData;
logic upstreamRequestFifoReadEnable;
logic upstreamRequestFifoEmpty;
chunkRequestType upstreamRequestFifoReadData;
logic upstreamResponseFifoWriteEnable;
logic upstreamResponseFifoFull;
pixelType upstreamResponseFifoWriteData;

logic [31:0] randomState;
int mismatchCount;
int failureCount;
int pixelsSeen;
int pixelIndex;
logic resetSampled;
logic upstreamFullSeen;
logic previousFull;

// Requests the downstream element still has to hand over
chunkRequestType requestSource [$];
// Translated requests the upstream element should see, in order
chunkRequestType expectedUpstream [$];
// Every pixel the downstream element should receive, in order
pixelType expectedPixels [$];
// Chunks the upstream model has popped but not yet fully supplied
chunkRequestType owedChunks [$];

scalerClockGen clockGen (.scalerClock(scalerClock), .reset(reset));

videoPaddingFilter #(.fifoAddrBits(3)) dut (.*);

function automatic logic [31:0] nextRandom();
    randomState = randomState ^ (randomState << 13);
    randomState = randomState ^ (randomState >> 17);
    randomState = randomState ^ (randomState << 5);
    return randomState;
endfunction

// Pixel the upstream model supplies for a given source chunk and position
function automatic pixelType sourcePixel(input chunkRequestType request, input int index);
    return pixelType'(request.row) ^ (pixelType'(request.chunk) << 6) ^ (pixelType'(index) << 11);
endfunction

task automatic compareRequest(input string name, input chunkRequestType actual,
                              input chunkRequestType expected);
    if (actual !== expected) begin
        mismatchCount++;
        $display("mismatch at %0t: %s is row %0d chunk %0d, expected row %0d chunk %0d",
                 $time, name, actual.row, actual.chunk, expected.row, expected.chunk);
    end
endtask

task automatic comparePixel(input string name, input pixelType actual, input pixelType expected);
    if (actual !== expected) begin
        mismatchCount++;
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
endtask

task automatic compareFlag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        mismatchCount++;
        $display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
    end
endtask

task automatic compareCount(input string name, input int actual, input int expected);
    if (actual != expected) begin
        mismatchCount++;
        $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
    end
endtask

task automatic finishRun();
    int assertionFailures;
    assertionFailures = dut.protocolChecks.assertionFailures;
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatchCount, failureCount, assertionFailures);
    if (mismatchCount == 0 && failureCount == 0 && assertionFailures == 0) begin
        $display("Simulation PASSED");
    end else begin
        $display("Simulation FAILED");
    end
    $finish;
endtask

// Reset changes on falling edges, so its value at the rising edge is settled
always @(posedge scalerClock) begin
    resetSampled <= reset;
end

// All environment models share one block so the random draws keep a fixed order
always @(negedge scalerClock) begin
    if (!resetSampled) begin
        // Request FIFO model puts the next entry on readData one cycle after the pulse
        if (downstreamRequestFifoReadEnable) begin
            if (requestSource.size() == 0) begin
                failureCount++;
                $display("At %0t the DUT read from an empty request FIFO", $time);
            end else begin
                downstreamRequestFifoReadData = requestSource.pop_front();
            end
        end
        downstreamRequestFifoEmpty = (requestSource.size() == 0);

        // Upstream model pops translated requests at random times
        if (upstreamRequestFifoReadEnable) begin
            upstreamRequestFifoReadEnable = 1'b0;
            if (expectedUpstream.size() == 0) begin
                failureCount++;
                $display("At %0t an upstream request appeared that no request asked for", $time);
            end else begin
                compareRequest("upstreamRequestFifoReadData", upstreamRequestFifoReadData,
                               expectedUpstream.pop_front());
            end
            owedChunks.push_back(upstreamRequestFifoReadData);
        end else if (!upstreamRequestFifoEmpty && (nextRandom() % 4) != 0) begin
            upstreamRequestFifoReadEnable = 1'b1;
        end

        // The pixel offered last cycle was taken if full was low during that cycle
        if (upstreamResponseFifoWriteEnable && !upstreamFullSeen) begin
            pixelIndex++;
            if (pixelIndex == chunkSize) begin
                void'(owedChunks.pop_front());
                pixelIndex = 0;
            end
        end
        upstreamResponseFifoWriteEnable = 1'b0;
        if (owedChunks.size() != 0 && (nextRandom() % 3) != 0) begin
            upstreamResponseFifoWriteEnable = 1'b1;
            upstreamResponseFifoWriteData = sourcePixel(owedChunks[0], pixelIndex);
        end
        upstreamFullSeen = upstreamResponseFifoFull;

        // Response FIFO model takes every write and checks it against the expected stream
        if (downstreamResponseFifoWriteEnable) begin
            // Only the one write already under way may follow a cycle with full high
            if (downstreamResponseFifoFull && previousFull) begin
                failureCount++;
                $display("At %0t a pixel was written while the response FIFO stayed full",
                         $time);
            end
            pixelsSeen++;
            if (expectedPixels.size() == 0) begin
                failureCount++;
                $display("At %0t a pixel was written after the last chunk", $time);
            end else begin
                comparePixel("downstreamResponseFifoWriteData", downstreamResponseFifoWriteData,
                             expectedPixels.pop_front());
            end
        end
        previousFull = downstreamResponseFifoFull;
        downstreamResponseFifoFull = ((nextRandom() % 5) == 0);
    end
end

initial begin
    chunkRequestType request;
    chunkRequestType translated;
    logic insideWindow;
    int waitCycles;
    padTopRows = rowType'(windowTop);
    sourceRows = rowType'(windowRows);
    padLeftChunks = chunkNumType'(windowLeft);
    sourceChunks = chunkNumType'(windowChunks);
    padColor = padColorValue;
    downstreamRequestFifoEmpty = 1'b1;
    downstreamRequestFifoReadData = '0;
    downstreamResponseFifoFull = 1'b0;
    upstreamRequestFifoReadEnable = 1'b0;
    upstreamResponseFifoWriteEnable = 1'b0;
    upstreamResponseFifoWriteData = '0;
    upstreamFullSeen = 1'b1;
    previousFull = 1'b0;
    randomState = randomSeed;
    mismatchCount = 0;
    failureCount = 0;
    pixelsSeen = 0;
    pixelIndex = 0;

    // Random requests over rows 0 to 10 and chunks 0 to 8, rows 8 and up fall in the trimmed part
    for (int i = 0; i < requestCount; i++) begin
        request.row = rowType'(nextRandom() % 11);
        request.chunk = chunkNumType'(nextRandom() % 9);
        insideWindow = (int'(request.row) >= windowTop) &&
                       (int'(request.row) < windowTop + windowRows) &&
                       (int'(request.chunk) >= windowLeft) &&
                       (int'(request.chunk) < windowLeft + windowChunks);
        translated.row = rowType'(int'(request.row) - windowTop);
        translated.chunk = chunkNumType'(int'(request.chunk) - windowLeft);
        requestSource.push_back(request);
        if (insideWindow) begin
            expectedUpstream.push_back(translated);
        end
        for (int p = 0; p < chunkSize; p++) begin
            expectedPixels.push_back(insideWindow ? sourcePixel(translated, p) : padColorValue);
        end
    end

    // Reset values must still show on the first clock after reset is released
    waitCycles = 0;
    do begin
        @(posedge scalerClock);
        waitCycles++;
    end while (reset && waitCycles < resetTimeout);
    if (reset) begin
        failureCount++;
        $display("Timed out waiting for reset to be released");
    end
    @(negedge scalerClock);
    compareFlag("downstreamRequestFifoReadEnable", downstreamRequestFifoReadEnable, 1'b0);
    compareFlag("downstreamResponseFifoWriteEnable", downstreamResponseFifoWriteEnable, 1'b0);
    compareFlag("upstreamResponseFifoFull", upstreamResponseFifoFull, 1'b1);
    compareFlag("upstreamRequestFifoEmpty", upstreamRequestFifoEmpty, 1'b1);

    waitCycles = 0;
    while (pixelsSeen < pixelTotal && waitCycles < drainTimeout) begin
        @(posedge scalerClock);
        waitCycles++;
    end
    if (pixelsSeen < pixelTotal) begin
        failureCount++;
        $display("Timed out with %0d of %0d pixels delivered", pixelsSeen, pixelTotal);
    end else begin
        // Stray writes after the last chunk would raise the count
        waitCycles = 0;
        while (waitCycles < quietCycles) begin
            @(posedge scalerClock);
            waitCycles++;
        end
        compareCount("downstream pixel count", pixelsSeen, pixelTotal);
        compareCount("upstream requests not delivered", expectedUpstream.size(), 0);
        compareCount("downstream requests not read", requestSource.size(), 0);
    end
    finishRun();
end

endmodule

/* sources.f */
design/videoGeometryPkg.sv
design/paddingControlPkg.sv
design/chunkQueueIf.sv
design/chunkQueue.sv
design/requestTranslator.sv
design/responseAssembler.sv
design/videoPaddingFilter.sv
verification/scalerClockGen.sv
verification/videoPaddingFilter_assert.sv
verification/videoPaddingFilterTb.sv
